// File: dl1_ctrl_pkg.sv
package dl1_ctrl_pkg;

	// ============================================================
	// Cache geometry
	// ============================================================
	localparam int DATA_LENGTH     = 32;
	localparam int DCACHE_WAY      = 4;
	localparam int DCACHE_LINE     = 64;
	localparam int BYTE_OFFSET     = 2;
	localparam int WORD_OFFSET     = 3;

	// Derived widths
	localparam int WORDS_PER_BLOCK = 1 << WORD_OFFSET;
	localparam int WORD_SEL_W      = $clog2(WORDS_PER_BLOCK);
	localparam int INDEX_W         = $clog2(DCACHE_LINE);
	localparam int TAG_LSB         = BYTE_OFFSET + WORD_OFFSET + INDEX_W;
	localparam int TAG_LENGTH      = DATA_LENGTH - TAG_LSB;

	// ============================================================
	// State encodings
	// ============================================================
	typedef enum logic [2:0]
	{
		IDLE,
		WAIT_WB,
		HALT_REPLACE,
		HALT_DIRTY_1,
		HALT_DIRTY_2,
		CHALLENGE,
		PENALTY,
		WAIT_WRITE
	} miss_state_t;

	typedef enum logic
	{
		WB_EMPT,
		WB_DONE
	} wb_state_t;

	// ============================================================
	// Port bundles
	// ============================================================
	typedef struct packed
	{
		logic                   read;
		logic                   write;
		logic [DATA_LENGTH-1:0] addr;
	} cpu_req_t;

	typedef struct packed
	{
		logic dcache_hit;
		logic vc_hit;
		logic wb_hit;
		logic wb_read_tag_hit;
	} lookup_t;

	// Per-way masks from the tag array and the replacement logic
	typedef struct packed
	{
		logic [DCACHE_WAY-1:0] valid;
		logic [DCACHE_WAY-1:0] dirty;
		logic [DCACHE_WAY-1:0] victim;
	} way_status_t;

	typedef struct packed
	{
		logic full;
		logic empty;
		logic done;
	} wb_status_t;

	typedef struct packed
	{
		logic [DATA_LENGTH-1:0] dl1_data;
		logic [DATA_LENGTH-1:0] vc_data;
		logic [DATA_LENGTH-1:0] wb_hit_data;
		logic [DATA_LENGTH-1:0] update_data;
	} read_src_t;

	typedef struct packed
	{
		logic wb_trigger;
		logic wb_write;
		logic wb_read;
	} wb_ctrl_t;

endpackage

// File: dl1_miss_fsm.sv
`timescale 1ns/1ns

module dl1_miss_fsm import dl1_ctrl_pkg::*;
(
	input  logic                  cache_clk,
	input  logic                  rst_n,
	input  cpu_req_t              cpu,
	input  lookup_t               look,
	input  way_status_t           ways,
	input  logic                  wb_full,
	input  logic                  update,
	input  logic                  dirty_done,
	input  logic                  same_tag,
	output logic                  halt,
	output logic                  dirty_replace,
	output logic [WORD_SEL_W-1:0] dirty_word_sel,
	output logic                  dirty_trigger,
	output logic                  update_trigger,
	output logic                  update_vc,
	output logic                  capture_en
);

	miss_state_t state;
	miss_state_t next_state;

	logic miss_read;
	logic miss_write;
	logic miss;
	logic dirty;
	logic all_valid;
	logic halt_req;
	logic update_req;
	logic dirty_req;
	logic update_q;
	logic update_q2;
	logic dirty_q;
	logic dirty_q2;

	// ============================================================
	// Miss detection
	// ============================================================
	assign miss_read  = cpu.read && !look.dcache_hit && !look.vc_hit && !look.wb_hit;
	assign miss_write = cpu.write && !look.dcache_hit && !look.wb_hit && wb_full;
	assign miss       = miss_read || miss_write;
	// Victim line needs a write-back first
	assign dirty      = |(ways.dirty & ways.victim);
	assign all_valid  = &ways.valid;

	// Address and victim are sampled while the refill is pending
	assign capture_en = (state == HALT_REPLACE);

	// ============================================================
	// Miss, write-back and refill FSM
	// ============================================================
	always_comb
	begin
		next_state    = state;
		halt_req      = 1'b0;
		update_req    = 1'b0;
		dirty_req     = 1'b0;
		dirty_replace = 1'b0;
		unique case (state)
			IDLE:
			begin
				if (miss && look.wb_read_tag_hit)
				begin
					halt_req   = 1'b1;
					next_state = WAIT_WB;
				end
				else if (miss && !dirty)
				begin
					halt_req   = 1'b1;
					update_req = 1'b1;
					next_state = HALT_REPLACE;
				end
				else if (miss && dirty)
				begin
					halt_req      = 1'b1;
					dirty_replace = 1'b1;
					next_state    = HALT_DIRTY_1;
				end
			end
			WAIT_WB:
			begin
				// Line still in flight in the write buffer
				halt_req = 1'b1;
				if (!look.wb_read_tag_hit)
					next_state = IDLE;
			end
			HALT_REPLACE:
			begin
				halt_req = 1'b1;
				if (update && cpu.read)
				begin
					halt_req   = 1'b0;
					next_state = CHALLENGE;
				end
				else if (update && cpu.write)
					next_state = WAIT_WRITE;
			end
			HALT_DIRTY_1:
			begin
				halt_req      = 1'b1;
				dirty_replace = 1'b1;
				if (dirty_word_sel == WORD_SEL_W'(WORDS_PER_BLOCK - 1))
				begin
					dirty_req  = 1'b1;
					next_state = HALT_DIRTY_2;
				end
			end
			HALT_DIRTY_2:
			begin
				halt_req = 1'b1;
				if (dirty_done)
				begin
					update_req = 1'b1;
					next_state = HALT_REPLACE;
				end
			end
			CHALLENGE:
			begin
				// CPU runs on streamed refill words
				if (!miss && !update)
					next_state = IDLE;
				else if (miss)
				begin
					halt_req   = 1'b1;
					next_state = PENALTY;
				end
				else if (cpu.write && same_tag)
				begin
					halt_req   = 1'b1;
					next_state = WAIT_WRITE;
				end
			end
			PENALTY:
			begin
				halt_req = 1'b1;
				if (!update && dirty)
				begin
					dirty_replace = 1'b1;
					next_state    = HALT_DIRTY_1;
				end
				else if (!update)
				begin
					update_req = 1'b1;
					next_state = HALT_REPLACE;
				end
			end
			WAIT_WRITE:
			begin
				halt_req = 1'b1;
				if (!update)
				begin
					halt_req   = 1'b0;
					next_state = IDLE;
				end
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= next_state;
	end

	// Write-back word counter
	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
			dirty_word_sel <= '0;
		else if (!dirty_replace)
			dirty_word_sel <= '0;
		else
			dirty_word_sel <= dirty_word_sel + 1'b1;
	end

	// ============================================================
	// Halt register and request edge detectors
	// ============================================================
	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			halt      <= 1'b0;
			update_q  <= 1'b0;
			update_q2 <= 1'b0;
			dirty_q   <= 1'b0;
			dirty_q2  <= 1'b0;
		end
		else
		begin
			halt      <= halt_req;
			update_q  <= update_req;
			update_q2 <= update_q;
			dirty_q   <= dirty_req;
			dirty_q2  <= dirty_q;
		end
	end

	assign update_trigger = update_q && !update_q2;
	assign dirty_trigger  = dirty_q && !dirty_q2;
	// Victim cache takes the evicted line only when the set is full
	assign update_vc      = all_valid && update_trigger;

endmodule

// File: dl1_refill_latch.sv
`timescale 1ns/1ns

module dl1_refill_latch import dl1_ctrl_pkg::*;
(
	input  logic                   cache_clk,
	input  logic                   rst_n,
	input  logic                   capture_en,
	input  logic [DATA_LENGTH-1:0] addr,
	input  logic [DCACHE_WAY-1:0]  victim_way,
	input  logic                   update,
	output logic                   same_tag,
	output logic                   same_addr,
	output logic [DCACHE_WAY-1:0]  replace_way
);

	logic [DATA_LENGTH-1:0] miss_addr;
	logic [DCACHE_WAY-1:0]  miss_way;
	logic [TAG_LENGTH-1:0]  tag;
	logic [TAG_LENGTH-1:0]  miss_tag;

	// ============================================================
	// Missing address and victim way
	// ============================================================
	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			miss_addr <= '0;
			miss_way  <= '0;
		end
		else if (capture_en)
		begin
			miss_addr <= addr;
			miss_way  <= victim_way;
		end
	end

	// Compare live request against the line being refilled
	assign tag       = addr[DATA_LENGTH-1:TAG_LSB];
	assign miss_tag  = miss_addr[DATA_LENGTH-1:TAG_LSB];
	assign same_tag  = (tag == miss_tag);
	assign same_addr = (addr == miss_addr);

	// Way select only valid during refill
	assign replace_way = update ? miss_way : '0;

endmodule

// File: dl1_wb_drain.sv
`timescale 1ns/1ns

module dl1_wb_drain import dl1_ctrl_pkg::*;
(
	input  logic       cache_clk,
	input  logic       rst_n,
	input  logic       cpu_write,
	input  logic       dcache_hit,
	input  logic       wb_hit,
	input  wb_status_t wb,
	input  logic       l2_full,
	output wb_ctrl_t   ctrl
);

	wb_state_t state;
	wb_state_t next_state;

	logic wb_write_q;
	logic trig_req;
	logic read_req;
	logic trig_q;
	logic trig_q1;
	logic trig_q2;
	logic read_q;
	logic read_q1;
	logic read_q2;

	// Write strobe into the buffer that also merges on a buffer hit
	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
			wb_write_q <= 1'b0;
		else
			wb_write_q <= cpu_write && !dcache_hit && (!wb.full || wb_hit);
	end

	// ============================================================
	// Drain FSM
	// ============================================================
	always_comb
	begin
		next_state = state;
		trig_req   = 1'b0;
		read_req   = 1'b0;
		unique case (state)
			WB_EMPT:
			begin
				// Next level must have room before a drain starts
				if (!wb.empty && !l2_full)
				begin
					trig_req   = 1'b1;
					next_state = WB_DONE;
				end
			end
			WB_DONE:
			begin
				if (wb.done)
				begin
					read_req   = 1'b1;
					next_state = WB_EMPT;
				end
			end
		endcase
	end

	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= WB_EMPT;
		else
			state <= next_state;
	end

	// Registered requests followed by edge detectors
	always_ff @(posedge cache_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			trig_q  <= 1'b0;
			trig_q1 <= 1'b0;
			trig_q2 <= 1'b0;
			read_q  <= 1'b0;
			read_q1 <= 1'b0;
			read_q2 <= 1'b0;
		end
		else
		begin
			trig_q  <= trig_req;
			trig_q1 <= trig_q;
			trig_q2 <= trig_q1;
			read_q  <= read_req;
			read_q1 <= read_q;
			read_q2 <= read_q1;
		end
	end

	always_comb
	begin
		ctrl.wb_trigger = trig_q1 && !trig_q2;
		ctrl.wb_write   = wb_write_q;
		ctrl.wb_read    = read_q1 && !read_q2;
	end

endmodule

// File: dl1_read_mux.sv
`timescale 1ns/1ns

module dl1_read_mux import dl1_ctrl_pkg::*;
(
	input  read_src_t              src,
	input  lookup_t                look,
	input  logic                   update,
	input  logic                   same_addr,
	output logic [DATA_LENGTH-1:0] data_out
);

	// ============================================================
	// CPU read data priority
	// ============================================================
	always_comb
	begin
		// Word streaming in from the refill wins over stale copies
		if (same_addr && update)
			data_out = src.update_data;
		else if (look.dcache_hit)
			data_out = src.dl1_data;
		else if (look.vc_hit)
			data_out = src.vc_data;
		else if (look.wb_hit)
			data_out = src.wb_hit_data;
		else
			data_out = '0;
	end

endmodule

// File: dl1_controller.sv
`timescale 1ns/1ns

module dl1_controller import dl1_ctrl_pkg::*;
(
	input  logic                   cache_clk,
	input  logic                   rst_n,
	input  cpu_req_t               cpu,
	input  lookup_t                look,
	input  way_status_t            ways,
	input  wb_status_t             wb,
	input  read_src_t              src,
	input  logic                   update,
	input  logic                   dirty_done,
	input  logic                   l2_full,
	output logic [DATA_LENGTH-1:0] data_out,
	output logic                   halt,
	output logic                   dirty_replace,
	output logic [WORD_SEL_W-1:0]  dirty_word_sel,
	output logic                   dirty_trigger,
	output logic                   update_trigger,
	output logic                   update_vc,
	output logic [DCACHE_WAY-1:0]  replace_way,
	output wb_ctrl_t               wb_ctrl
);

	logic capture_en;
	logic same_tag;
	logic same_addr;

	// ============================================================
	// Miss handling
	// ============================================================
	dl1_miss_fsm u_miss_fsm
	(
		.cache_clk      (cache_clk),
		.rst_n          (rst_n),
		.cpu            (cpu),
		.look           (look),
		.ways           (ways),
		.wb_full        (wb.full),
		.update         (update),
		.dirty_done     (dirty_done),
		.same_tag       (same_tag),
		.halt           (halt),
		.dirty_replace  (dirty_replace),
		.dirty_word_sel (dirty_word_sel),
		.dirty_trigger  (dirty_trigger),
		.update_trigger (update_trigger),
		.update_vc      (update_vc),
		.capture_en     (capture_en)
	);

	dl1_refill_latch u_refill_latch
	(
		.cache_clk   (cache_clk),
		.rst_n       (rst_n),
		.capture_en  (capture_en),
		.addr        (cpu.addr),
		.victim_way  (ways.victim),
		.update      (update),
		.same_tag    (same_tag),
		.same_addr   (same_addr),
		.replace_way (replace_way)
	);

	// ============================================================
	// Write buffer and read path
	// ============================================================
	dl1_wb_drain u_wb_drain
	(
		.cache_clk  (cache_clk),
		.rst_n      (rst_n),
		.cpu_write  (cpu.write),
		.dcache_hit (look.dcache_hit),
		.wb_hit     (look.wb_hit),
		.wb         (wb),
		.l2_full    (l2_full),
		.ctrl       (wb_ctrl)
	);

	dl1_read_mux u_read_mux
	(
		.src       (src),
		.look      (look),
		.update    (update),
		.same_addr (same_addr),
		.data_out  (data_out)
	);

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen
(
	output logic cache_clk,
	output logic rst_n
);

	// Reset held low for the first 16 cycles
	initial
	begin
		cache_clk = 1'b0;
		rst_n     = 1'b0;
		repeat (16) @(posedge cache_clk);
		rst_n <= 1'b1;
	end

	always #4 cache_clk = ~cache_clk;

endmodule

// File: dl1_controller_tb.sv
`timescale 1ns/1ns

module dl1_controller_tb import dl1_ctrl_pkg::*; ();

	typedef enum logic [2:0] {READ_HIT, CLEAN_MISS, DIRTY_MISS, TAG_WAIT, WRITE_DRAIN} kind_t;
	typedef enum logic [1:0] {SEL_DL1, SEL_VC, SEL_WB, SEL_NONE} sel_t;
	typedef enum logic [2:0] {P_HALT, P_DIRTY_REP, P_UPD_TRIG, P_WB_TRIG, P_WB_READ} probe_t;

	// One table row with scenario, lookup flags, way masks and expected results
	typedef struct packed
	{
		kind_t                 kind;
		lookup_t               look;
		logic [DCACHE_WAY-1:0] valid;
		logic [DCACHE_WAY-1:0] dirty;
		logic [DCACHE_WAY-1:0] victim;
		sel_t                  exp_sel;
		logic                  exp_vc;
	} row_t;

	logic                   cache_clk;
	logic                   rst_n;
	cpu_req_t               cpu;
	lookup_t                look;
	way_status_t            ways;
	wb_status_t             wb;
	read_src_t              src;
	logic                   update;
	logic                   dirty_done;
	logic                   l2_full;
	logic [DATA_LENGTH-1:0] data_out;
	logic                   halt;
	logic                   dirty_replace;
	logic [WORD_SEL_W-1:0]  dirty_word_sel;
	logic                   dirty_trigger;
	logic                   update_trigger;
	logic                   update_vc;
	logic [DCACHE_WAY-1:0]  replace_way;
	wb_ctrl_t               wb_ctrl;

	row_t        rows[$];
	logic [31:0] seed = 32'hc0f190a7;
	logic        table_ready = 1'b0;
	logic        vc_expect = 1'b0;
	int          checks = 0;
	int          value_errors = 0;
	int          other_errors = 0;
	int          upd_pulses = 0;
	int          dirty_pulses = 0;
	int          trig_pulses = 0;
	int          read_pulses = 0;

	tb_clock_gen u_clock_gen
	(
		.cache_clk (cache_clk),
		.rst_n     (rst_n)
	);

	dl1_controller uut
	(
		.cache_clk      (cache_clk),
		.rst_n          (rst_n),
		.cpu            (cpu),
		.look           (look),
		.ways           (ways),
		.wb             (wb),
		.src            (src),
		.update         (update),
		.dirty_done     (dirty_done),
		.l2_full        (l2_full),
		.data_out       (data_out),
		.halt           (halt),
		.dirty_replace  (dirty_replace),
		.dirty_word_sel (dirty_word_sel),
		.dirty_trigger  (dirty_trigger),
		.update_trigger (update_trigger),
		.update_vc      (update_vc),
		.replace_way    (replace_way),
		.wb_ctrl        (wb_ctrl)
	);

	// ============================================================
	// Helpers
	// ============================================================
	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic probe(input probe_t which);
		case (which)
			P_HALT:      return halt;
			P_DIRTY_REP: return dirty_replace;
			P_UPD_TRIG:  return update_trigger;
			P_WB_TRIG:   return wb_ctrl.wb_trigger;
			P_WB_READ:   return wb_ctrl.wb_read;
			default:     return 1'b0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected)
		begin
			value_errors++;
			$display("[FAIL] %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
		end
	endtask

	// Returns the falling edges waited or zero when the level never came
	task automatic wait_level(input probe_t which, input logic level, input int max_cycles,
		output int cycles);
		int i;
		cycles = 0;
		i = 0;
		while (cycles == 0 && i < max_cycles)
		begin
			@(negedge cache_clk);
			i++;
			if (probe(which) === level)
				cycles = i;
		end
		if (cycles == 0)
		begin
			other_errors++;
			$display("At %0t ns %s did not reach %0b within %0d cycles",
				$time, which.name(), level, max_cycles);
		end
	endtask

	task automatic add_row(input kind_t kind, input lookup_t look_v,
		input logic [DCACHE_WAY-1:0] valid, input logic [DCACHE_WAY-1:0] dirty,
		input logic [DCACHE_WAY-1:0] victim, input sel_t exp_sel, input logic exp_vc);
		row_t r;
		r.kind    = kind;
		r.look    = look_v;
		r.valid   = valid;
		r.dirty   = dirty;
		r.victim  = victim;
		r.exp_sel = exp_sel;
		r.exp_vc  = exp_vc;
		rows.push_back(r);
	endtask

	task automatic clear_counts();
		upd_pulses   = 0;
		dirty_pulses = 0;
		trig_pulses  = 0;
		read_pulses  = 0;
	endtask

	task automatic drive_idle();
		cpu        <= '0;
		look       <= '0;
		update     <= 1'b0;
		dirty_done <= 1'b0;
		l2_full    <= 1'b0;
		wb.full    <= 1'b0;
		wb.empty   <= 1'b1;
		wb.done    <= 1'b0;
	endtask

	task automatic load_random_sources();
		src.dl1_data    <= next_random();
		src.vc_data     <= next_random();
		src.wb_hit_data <= next_random();
		src.update_data <= next_random();
	endtask

	// Pulse counters and victim cache strobe sampled mid-cycle
	always @(negedge cache_clk)
	begin
		if (update_trigger)
			upd_pulses++;
		if (dirty_trigger)
			dirty_pulses++;
		if (wb_ctrl.wb_trigger)
			trig_pulses++;
		if (wb_ctrl.wb_read)
			read_pulses++;
		if (rst_n === 1'b1)
			check_value("update_vc", update_vc, update_trigger && vc_expect);
	end

	// ============================================================
	// Scenarios
	// ============================================================
	task automatic run_read_hit(input row_t r);
		logic [DATA_LENGTH-1:0] expected;
		@(posedge cache_clk);
		cpu.read  <= (r.exp_sel != SEL_NONE);
		cpu.write <= 1'b0;
		cpu.addr  <= next_random();
		look      <= r.look;
		load_random_sources();
		@(negedge cache_clk);
		case (r.exp_sel)
			SEL_DL1: expected = src.dl1_data;
			SEL_VC:  expected = src.vc_data;
			SEL_WB:  expected = src.wb_hit_data;
			default: expected = '0;
		endcase
		check_value("data_out", data_out, expected);
		@(negedge cache_clk);
		check_value("halt", halt, 1'b0);
	endtask

	task automatic start_miss(input row_t r);
		@(posedge cache_clk);
		clear_counts();
		cpu.read    <= 1'b1;
		cpu.write   <= 1'b0;
		cpu.addr    <= next_random();
		look        <= r.look;
		ways.valid  <= r.valid;
		ways.dirty  <= r.dirty;
		ways.victim <= r.victim;
		vc_expect   <= r.exp_vc;
		load_random_sources();
	endtask

	// Refill engine streams the line, then the request is released
	task automatic complete_refill(input row_t r);
		int cycles;
		repeat (3) @(posedge cache_clk);
		check_value("update_trigger pulses", upd_pulses, 1);
		update          <= 1'b1;
		look.dcache_hit <= 1'b1;
		@(negedge cache_clk);
		check_value("halt", halt, 1'b1);
		check_value("replace_way", replace_way, r.victim);
		check_value("data_out", data_out, src.update_data);
		wait_level(P_HALT, 1'b0, 4, cycles);
		@(posedge cache_clk);
		update <= 1'b0;
		@(posedge cache_clk);
		drive_idle();
		@(negedge cache_clk);
		check_value("replace_way", replace_way, '0);
		repeat (2) @(negedge cache_clk);
		check_value("halt", halt, 1'b0);
		@(posedge cache_clk);
		check_value("update_trigger pulses", upd_pulses, 1);
	endtask

	task automatic run_dirty_miss(input row_t r);
		int cycles;
		int k;
		start_miss(r);
		wait_level(P_DIRTY_REP, 1'b1, 8, cycles);
		for (k = 0; k < WORDS_PER_BLOCK; k++)
		begin
			if (k > 0)
				@(negedge cache_clk);
			check_value("dirty_replace", dirty_replace, 1'b1);
			check_value("dirty_word_sel", dirty_word_sel, k);
		end
		@(negedge cache_clk);
		check_value("dirty_replace", dirty_replace, 1'b0);
		// Write-back engine busy for a while
		repeat (5) @(posedge cache_clk);
		check_value("dirty_trigger pulses", dirty_pulses, 1);
		check_value("update_trigger pulses", upd_pulses, 0);
		dirty_done <= 1'b1;
		wait_level(P_UPD_TRIG, 1'b1, 8, cycles);
		@(posedge cache_clk);
		dirty_done <= 1'b0;
		complete_refill(r);
		check_value("dirty_trigger pulses", dirty_pulses, 1);
	endtask

	task automatic run_tag_wait(input row_t r);
		int cycles;
		start_miss(r);
		wait_level(P_HALT, 1'b1, 8, cycles);
		repeat (6)
		begin
			@(negedge cache_clk);
			check_value("halt", halt, 1'b1);
		end
		@(posedge cache_clk);
		check_value("update_trigger pulses", upd_pulses, 0);
		look.wb_read_tag_hit <= 1'b0;
		wait_level(P_UPD_TRIG, 1'b1, 8, cycles);
		complete_refill(r);
	endtask

	task automatic run_write_drain(input row_t r);
		int cycles;
		@(posedge cache_clk);
		clear_counts();
		cpu.read  <= 1'b0;
		cpu.write <= 1'b1;
		cpu.addr  <= next_random();
		look      <= r.look;
		l2_full   <= 1'b1;
		@(posedge cache_clk);
		cpu.write <= 1'b0;
		@(negedge cache_clk);
		check_value("wb_write", wb_ctrl.wb_write, 1'b1);
		@(negedge cache_clk);
		check_value("wb_write", wb_ctrl.wb_write, 1'b0);
		// Buffer holds data while the next level is full
		@(posedge cache_clk);
		wb.empty <= 1'b0;
		repeat (6) @(posedge cache_clk);
		check_value("wb_trigger pulses", trig_pulses, 0);
		l2_full <= 1'b0;
		wait_level(P_WB_TRIG, 1'b1, 8, cycles);
		// Trigger seen in the first cycle and pulsed two cycles later
		check_value("wb_trigger latency", cycles, 1 + 2);
		repeat (4) @(posedge cache_clk);
		check_value("wb_trigger pulses", trig_pulses, 1);
		wb.empty <= 1'b1;
		wb.done  <= 1'b1;
		wait_level(P_WB_READ, 1'b1, 8, cycles);
		check_value("wb_read latency", cycles, 1 + 2);
		@(posedge cache_clk);
		wb.done <= 1'b0;
		repeat (4) @(posedge cache_clk);
		check_value("wb_read pulses", read_pulses, 1);
		check_value("wb_trigger pulses", trig_pulses, 1);
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial
	begin
		int row_idx;
		int cycles;
		cpu        = '0;
		look       = '0;
		ways       = '0;
		wb         = '0;
		wb.empty   = 1'b1;
		src        = '0;
		update     = 1'b0;
		dirty_done = 1'b0;
		l2_full    = 1'b0;

		// Lookup flags are dcache_hit, vc_hit, wb_hit, wb_read_tag_hit
		add_row(READ_HIT,    4'b1110, 4'hf,    4'h0,    4'b0001, SEL_DL1,  1'b0);
		add_row(READ_HIT,    4'b0110, 4'hf,    4'h0,    4'b0001, SEL_VC,   1'b0);
		add_row(READ_HIT,    4'b0010, 4'hf,    4'h0,    4'b0001, SEL_WB,   1'b0);
		add_row(READ_HIT,    4'b0000, 4'hf,    4'h0,    4'b0001, SEL_NONE, 1'b0);
		add_row(CLEAN_MISS,  4'b0000, 4'hf,    4'h0,    4'b0100, SEL_NONE, 1'b1);
		add_row(CLEAN_MISS,  4'b0000, 4'b0111, 4'b1000, 4'b0001, SEL_NONE, 1'b0);
		add_row(DIRTY_MISS,  4'b0000, 4'hf,    4'b0010, 4'b0010, SEL_NONE, 1'b1);
		add_row(DIRTY_MISS,  4'b0000, 4'b1011, 4'b1001, 4'b1000, SEL_NONE, 1'b0);
		add_row(TAG_WAIT,    4'b0001, 4'hf,    4'h0,    4'b0001, SEL_NONE, 1'b1);
		add_row(WRITE_DRAIN, 4'b0000, 4'hf,    4'h0,    4'b0001, SEL_NONE, 1'b0);
		table_ready = 1'b1;

		wait (rst_n === 1'b1);
		@(negedge cache_clk);
		check_value("halt", halt, 1'b0);
		check_value("dirty_replace", dirty_replace, 1'b0);
		check_value("dirty_word_sel", dirty_word_sel, 0);
		check_value("dirty_trigger", dirty_trigger, 1'b0);
		check_value("update_trigger", update_trigger, 1'b0);
		check_value("update_vc", update_vc, 1'b0);
		check_value("replace_way", replace_way, 0);
		check_value("wb_ctrl", wb_ctrl, 0);

		for (row_idx = 0; row_idx < rows.size(); row_idx++)
		begin
			case (rows[row_idx].kind)
				READ_HIT:    run_read_hit(rows[row_idx]);
				CLEAN_MISS:
				begin
					start_miss(rows[row_idx]);
					wait_level(P_HALT, 1'b1, 8, cycles);
					complete_refill(rows[row_idx]);
				end
				DIRTY_MISS:  run_dirty_miss(rows[row_idx]);
				TAG_WAIT:    run_tag_wait(rows[row_idx]);
				default:     run_write_drain(rows[row_idx]);
			endcase
			@(posedge cache_clk);
			drive_idle();
		end

		repeat (2) @(posedge cache_clk);
		$display("Summary: %0d checks, %0d value errors, %0d other errors",
			checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Watchdog sized from the table length
	initial
	begin
		wait (table_ready === 1'b1);
		repeat (rows.size() * 200) @(posedge cache_clk);
		$display("Watchdog expired after %0d cycles, the run did not complete",
			rows.size() * 200);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: dl1_controller.f
dl1_ctrl_pkg.sv
dl1_miss_fsm.sv
dl1_refill_latch.sv
dl1_wb_drain.sv
dl1_read_mux.sv
dl1_controller.sv
tb_clock_gen.sv
dl1_controller_tb.sv

// File: Bender.yml
package:
  name: dl1_controller

sources:
  - dl1_ctrl_pkg.sv
  - dl1_miss_fsm.sv
  - dl1_refill_latch.sv
  - dl1_wb_drain.sv
  - dl1_read_mux.sv
  - dl1_controller.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - dl1_controller_tb.sv
